// ==== Makefile ====
# Verilator build for the AXI demux testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_demux
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q ">>> PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
logic/demux_pkg.sv
logic/txn_if.sv
logic/write_route.sv
logic/read_route.sv
logic/txn_budget.sv
logic/axi_demux_top.sv
dv/tb_axi_demux.sv

// ==== dv/tb_axi_demux.sv ====
/*
 * Testbench for the single-beat AXI demux
 * Slave drivers, master responders, scoreboard and checks
 */
`timescale 1ns/1ps

module tb_axi_demux;

  localparam int NP = 3;
  localparam int MAXT = 4;
  localparam int NUM_TXN = 100;     // Per channel, 200 in total
  localparam int LIMIT = 20000;     // 200 transactions at up to 100 cycles

  logic clk;
  logic rst_n;
  integer seed = 32'he963ed4b;
  int err_cnt = 0;
  int cycles = 0;

  // Slave side
  logic aw_valid, aw_ready_o, w_valid, w_ready_o, b_valid_o, b_ready;
  logic ar_valid, ar_ready_o, r_valid_o, r_ready;
  logic [3:0] aw_id, ar_id, b_id_o, r_id_o;
  logic [31:0] aw_addr, ar_addr, w_data, r_data_o;
  logic [3:0] w_strb;
  logic [1:0] aw_select, ar_select;
  demux_pkg::resp_e b_resp_o, r_resp_o;
  // Master side
  logic [NP-1:0] mst_aw_valid, mst_aw_ready, mst_w_valid, mst_w_ready;
  logic [NP-1:0] mst_ar_valid, mst_ar_ready, mst_b_valid, mst_b_ready;
  logic [NP-1:0] mst_r_valid, mst_r_ready;
  logic [3:0] mst_aw_id, mst_ar_id;
  logic [31:0] mst_aw_addr, mst_ar_addr, mst_w_data;
  logic [3:0] mst_w_strb;
  logic [3:0] mst_b_id [NP];
  logic [3:0] mst_r_id [NP];
  logic [31:0] mst_r_data [NP];
  demux_pkg::resp_e mst_b_resp [NP];
  demux_pkg::resp_e mst_r_resp [NP];

  axi_demux_top #(.NUM_PORTS(NP), .MAX_TRANS(MAXT)) dut (
    .clk_i(clk), .rst_n_i(rst_n),
    .aw_valid_i(aw_valid), .aw_ready_o, .aw_id_i(aw_id), .aw_addr_i(aw_addr),
    .aw_select_i(aw_select), .w_valid_i(w_valid), .w_ready_o,
    .w_data_i(w_data), .w_strb_i(w_strb),
    .b_valid_o, .b_ready_i(b_ready), .b_id_o, .b_resp_o,
    .ar_valid_i(ar_valid), .ar_ready_o, .ar_id_i(ar_id), .ar_addr_i(ar_addr),
    .ar_select_i(ar_select), .r_valid_o, .r_ready_i(r_ready), .r_id_o,
    .r_data_o, .r_resp_o,
    .mst_aw_valid_o(mst_aw_valid), .mst_aw_ready_i(mst_aw_ready),
    .mst_aw_id_o(mst_aw_id), .mst_aw_addr_o(mst_aw_addr),
    .mst_w_valid_o(mst_w_valid), .mst_w_ready_i(mst_w_ready),
    .mst_w_data_o(mst_w_data), .mst_w_strb_o(mst_w_strb),
    .mst_ar_valid_o(mst_ar_valid), .mst_ar_ready_i(mst_ar_ready),
    .mst_ar_id_o(mst_ar_id), .mst_ar_addr_o(mst_ar_addr),
    .mst_b_valid_i(mst_b_valid), .mst_b_id_i(mst_b_id), .mst_b_resp_i(mst_b_resp),
    .mst_b_ready_o(mst_b_ready),
    .mst_r_valid_i(mst_r_valid), .mst_r_id_i(mst_r_id), .mst_r_data_i(mst_r_data),
    .mst_r_resp_i(mst_r_resp), .mst_r_ready_o(mst_r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_run();
    err_cnt++;
    $display(">>> FAIL");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    stop_run();
  endtask

  task automatic fail_text(input string what);
    $display("ERROR: %s", what);
    stop_run();
  endtask

  // Scoreboard state, from slave side handshakes
  int wr_out = 0;
  int rd_out = 0;
  logic [1:0] wr_lock = '0;
  logic [1:0] rd_lock = '0;
  logic w_owed = 1'b0;
  logic rst_d = 1'b0;
  logic [3:0] exp_b_id [$];
  logic [3:0] exp_r_id [$];
  logic [31:0] exp_r_data [$];

  always @(posedge clk) begin : check_and_track
    cycles++;
    if (cycles >= LIMIT) fail_text("timeout, transactions did not finish in time");
    if (!rst_n || !rst_d) begin  // In reset and first cycle out
      assert ({mst_aw_valid, mst_w_valid, mst_ar_valid, b_valid_o, r_valid_o} == '0)
        else fail_value("valid outputs in reset",
                        {mst_aw_valid, mst_w_valid, mst_ar_valid, b_valid_o, r_valid_o}, 0);
    end
    if (rst_n) begin
      for (int p = 0; p < NP; p++) begin
        if (mst_aw_valid[p]) begin
          assert (aw_valid && aw_select == p) else fail_value("mst_aw_valid_o", p, aw_select);
          assert (mst_aw_addr == aw_addr) else fail_value("mst_aw_addr_o", mst_aw_addr, aw_addr);
          assert (mst_aw_id == aw_id) else fail_value("mst_aw_id_o", mst_aw_id, aw_id);
        end
        if (mst_ar_valid[p]) begin
          assert (ar_valid && ar_select == p) else fail_value("mst_ar_valid_o", p, ar_select);
          assert (mst_ar_addr == ar_addr) else fail_value("mst_ar_addr_o", mst_ar_addr, ar_addr);
          assert (mst_ar_id == ar_id) else fail_value("mst_ar_id_o", mst_ar_id, ar_id);
        end
        if (mst_w_valid[p]) begin
          assert (w_owed && w_valid) else fail_text("W reached a master without an owed AW");
          assert (wr_lock == p) else fail_value("mst_w_valid_o port", p, wr_lock);
          assert (mst_w_data == w_data) else fail_value("mst_w_data_o", mst_w_data, w_data);
          assert (mst_w_strb == w_strb) else fail_value("mst_w_strb_o", mst_w_strb, w_strb);
        end
        // Slave ready reaches the responding master in the same cycle
        if (mst_b_valid[p]) begin
          assert (mst_b_ready[p] == b_ready)
            else fail_value("mst_b_ready_o", mst_b_ready[p], b_ready);
        end
        if (mst_r_valid[p]) begin
          assert (mst_r_ready[p] == r_ready)
            else fail_value("mst_r_ready_o", mst_r_ready[p], r_ready);
        end
      end
      // Port lock per channel
      if (wr_out > 0 && aw_select != wr_lock)
        assert (!aw_ready_o) else fail_value("aw_ready_o on port change", aw_ready_o, 0);
      if (rd_out > 0 && ar_select != rd_lock)
        assert (!ar_ready_o) else fail_value("ar_ready_o on port change", ar_ready_o, 0);
      // Shared budget
      assert (wr_out + rd_out <= MAXT) else fail_value("outstanding", wr_out + rd_out, MAXT);
      if (wr_out + rd_out == MAXT) begin
        assert (!aw_ready_o) else fail_value("aw_ready_o at limit", aw_ready_o, 0);
        assert (!ar_ready_o) else fail_value("ar_ready_o at limit", ar_ready_o, 0);
      end
      if (aw_valid && aw_ready_o) begin
        assert (!w_owed) else fail_text("second AW accepted before its W");
        exp_b_id.push_back(aw_id);
        wr_lock = aw_select;
        w_owed = 1'b1;
        wr_out++;
      end
      if (w_valid && w_ready_o) w_owed = 1'b0;
      if (b_valid_o && b_ready) begin
        assert (exp_b_id.size() > 0) else fail_text("B arrived with no write outstanding");
        assert (b_id_o == exp_b_id[0]) else fail_value("b_id_o", b_id_o, exp_b_id[0]);
        assert (b_resp_o == demux_pkg::resp_e'(2'(exp_b_id[0])))  // Low ID bits
          else fail_value("b_resp_o", b_resp_o, 2'(exp_b_id[0]));
        void'(exp_b_id.pop_front());
        wr_out--;
      end
      if (ar_valid && ar_ready_o) begin
        exp_r_id.push_back(ar_id);
        exp_r_data.push_back(ar_addr ^ 32'(ar_select));  // Responder rule
        rd_lock = ar_select;
        rd_out++;
      end
      if (r_valid_o && r_ready) begin
        assert (exp_r_id.size() > 0) else fail_text("R arrived with no read outstanding");
        assert (r_id_o == exp_r_id[0]) else fail_value("r_id_o", r_id_o, exp_r_id[0]);
        assert (r_data_o == exp_r_data[0]) else fail_value("r_data_o", r_data_o, exp_r_data[0]);
        assert (r_resp_o == demux_pkg::resp_e'(2'(exp_r_id[0])))
          else fail_value("r_resp_o", r_resp_o, 2'(exp_r_id[0]));
        void'(exp_r_id.pop_front());
        void'(exp_r_data.pop_front());
        rd_out--;
      end
    end
    rst_d = rst_n;
  end

  // Master side models, capture on rising edge, drive on falling edge
  // Response code is the low two bits of the request ID
  initial begin : responders
    int aw_seen [$];          // port*16 + id, waiting for W
    int b_q [$];
    int r_port [$];
    logic [3:0] r_id_q [$];
    logic [31:0] r_data_q [$];
    int b_wait;
    int r_wait;
    logic b_busy;
    logic r_busy;
    b_wait = 0;
    r_wait = 0;
    b_busy = 1'b0;
    r_busy = 1'b0;
    forever begin
      @(posedge clk);
      for (int p = 0; p < NP; p++) begin
        if (mst_aw_valid[p] && mst_aw_ready[p]) aw_seen.push_back(p * 16 + mst_aw_id);
        if (mst_w_valid[p] && mst_w_ready[p] && aw_seen.size() > 0)
          b_q.push_back(aw_seen.pop_front());
        if (mst_ar_valid[p] && mst_ar_ready[p]) begin
          r_port.push_back(p);
          r_id_q.push_back(mst_ar_id);
          r_data_q.push_back(mst_ar_addr ^ 32'(p));
        end
      end
      @(negedge clk);
      if (b_busy && (mst_b_valid & mst_b_ready) != '0) begin  // B taken last edge
        void'(b_q.pop_front());
        mst_b_valid = '0;
        b_busy = 1'b0;
        b_wait = {$random(seed)} % 6;
      end
      if (r_busy && (mst_r_valid & mst_r_ready) != '0) begin
        void'(r_port.pop_front());
        void'(r_id_q.pop_front());
        void'(r_data_q.pop_front());
        mst_r_valid = '0;
        r_busy = 1'b0;
        r_wait = {$random(seed)} % 6;
      end
      if (!b_busy && b_q.size() > 0) begin
        if (b_wait > 0) b_wait--;
        else begin
          mst_b_valid[b_q[0] / 16] = 1'b1;
          mst_b_id[b_q[0] / 16] = 4'(b_q[0] % 16);
          mst_b_resp[b_q[0] / 16] = demux_pkg::resp_e'(2'(b_q[0] % 4));
          b_busy = 1'b1;
        end
      end
      if (!r_busy && r_port.size() > 0) begin
        if (r_wait > 0) r_wait--;
        else begin
          mst_r_valid[r_port[0]] = 1'b1;
          mst_r_id[r_port[0]] = r_id_q[0];
          mst_r_data[r_port[0]] = r_data_q[0];
          mst_r_resp[r_port[0]] = demux_pkg::resp_e'(2'(r_id_q[0]));
          r_busy = 1'b1;
        end
      end
      mst_aw_ready = 3'($random(seed));  // Random back-pressure
      mst_w_ready = 3'($random(seed));
      mst_ar_ready = 3'($random(seed));
      b_ready = 1'($random(seed));
      r_ready = 1'($random(seed));
    end
  end

  // Select mostly stays on one port so lock and budget both get exercised
  function automatic logic [1:0] pick_port(input logic [1:0] last);
    if ({$random(seed)} % 4 != 0) return last;
    return 2'({$random(seed)} % NP);
  endfunction

  // Next AW is offered right away, also while the last W is still owed
  task automatic send_aw(input logic [1:0] sel);
    aw_valid = 1'b1;
    aw_id = 4'($random(seed));
    aw_addr = $random(seed);
    aw_select = sel;
    do @(posedge clk); while (!aw_ready_o);
    @(negedge clk);
    aw_valid = 1'b0;
  endtask

  // W offered ahead of its AW too
  task automatic send_w();
    w_valid = 1'b1;
    w_data = $random(seed);
    w_strb = 4'($random(seed));
    do @(posedge clk); while (!w_ready_o);
    @(negedge clk);
    w_valid = 1'b0;
  endtask

  task automatic send_read(input logic [1:0] sel);
    ar_valid = 1'b1;
    ar_id = 4'($random(seed));
    ar_addr = $random(seed);
    ar_select = sel;
    do @(posedge clk); while (!ar_ready_o);
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  initial begin : stimulus
    logic [1:0] wsel;
    logic [1:0] rsel;
    rst_n = 1'b0;
    {aw_valid, w_valid, ar_valid, b_ready, r_ready} = '0;
    {aw_id, ar_id, aw_addr, ar_addr, w_data, w_strb, aw_select, ar_select} = '0;
    {mst_aw_ready, mst_w_ready, mst_ar_ready, mst_b_valid, mst_r_valid} = '0;
    for (int p = 0; p < NP; p++) begin
      mst_b_id[p] = '0;
      mst_r_id[p] = '0;
      mst_r_data[p] = '0;
      mst_b_resp[p] = demux_pkg::OKAY;
      mst_r_resp[p] = demux_pkg::OKAY;
    end
    wsel = '0;
    rsel = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);  // Leave the first cycle after reset quiet
    fork
      for (int i = 0; i < NUM_TXN; i++) begin
        wsel = pick_port(wsel);
        send_aw(wsel);
      end
      for (int i = 0; i < NUM_TXN; i++) begin
        send_w();
      end
      for (int i = 0; i < NUM_TXN; i++) begin
        rsel = pick_port(rsel);
        send_read(rsel);
      end
    join
    while (wr_out != 0 || rd_out != 0) @(posedge clk);  // Drain, cycle limit still applies
    if (exp_b_id.size() != 0 || exp_r_id.size() != 0)
      fail_text("responses still expected after the channels drained");
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== logic/axi_demux_top.sv ====
/*
 * Single-beat AXI demux, one slave port to NUM_PORTS master ports
 * Write and read paths run side by side under one transaction budget
 */
`timescale 1ns/1ps

module axi_demux_top #(
  parameter  int unsigned NUM_PORTS = 3,
  parameter  int unsigned MAX_TRANS = 4,  // Reads plus writes in flight
  localparam int unsigned SEL_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Slave AW
  input  logic                            aw_valid_i,
  output logic                            aw_ready_o,
  input  logic [demux_pkg::ID_W-1:0]      aw_id_i,
  input  logic [demux_pkg::ADDR_W-1:0]    aw_addr_i,
  input  logic [SEL_W-1:0]                aw_select_i,
  // Slave W
  input  logic                            w_valid_i,
  output logic                            w_ready_o,
  input  logic [demux_pkg::DATA_W-1:0]    w_data_i,
  input  logic [demux_pkg::DATA_W/8-1:0]  w_strb_i,
  // Slave B
  output logic                            b_valid_o,
  input  logic                            b_ready_i,
  output logic [demux_pkg::ID_W-1:0]      b_id_o,
  output demux_pkg::resp_e                b_resp_o,
  // Slave AR and R
  input  logic                            ar_valid_i,
  output logic                            ar_ready_o,
  input  logic [demux_pkg::ID_W-1:0]      ar_id_i,
  input  logic [demux_pkg::ADDR_W-1:0]    ar_addr_i,
  input  logic [SEL_W-1:0]                ar_select_i,
  output logic                            r_valid_o,
  input  logic                            r_ready_i,
  output logic [demux_pkg::ID_W-1:0]      r_id_o,
  output logic [demux_pkg::DATA_W-1:0]    r_data_o,
  output demux_pkg::resp_e                r_resp_o,
  // Master requests, payload shared by all ports
  output logic [NUM_PORTS-1:0]            mst_aw_valid_o,
  input  logic [NUM_PORTS-1:0]            mst_aw_ready_i,
  output logic [demux_pkg::ID_W-1:0]      mst_aw_id_o,
  output logic [demux_pkg::ADDR_W-1:0]    mst_aw_addr_o,
  output logic [NUM_PORTS-1:0]            mst_w_valid_o,
  input  logic [NUM_PORTS-1:0]            mst_w_ready_i,
  output logic [demux_pkg::DATA_W-1:0]    mst_w_data_o,
  output logic [demux_pkg::DATA_W/8-1:0]  mst_w_strb_o,
  output logic [NUM_PORTS-1:0]            mst_ar_valid_o,
  input  logic [NUM_PORTS-1:0]            mst_ar_ready_i,
  output logic [demux_pkg::ID_W-1:0]      mst_ar_id_o,
  output logic [demux_pkg::ADDR_W-1:0]    mst_ar_addr_o,
  // Master responses, one set per port
  input  logic [NUM_PORTS-1:0]            mst_b_valid_i,
  input  logic [demux_pkg::ID_W-1:0]      mst_b_id_i [NUM_PORTS],
  input  demux_pkg::resp_e                mst_b_resp_i [NUM_PORTS],
  output logic [NUM_PORTS-1:0]            mst_b_ready_o,
  input  logic [NUM_PORTS-1:0]            mst_r_valid_i,
  input  logic [demux_pkg::ID_W-1:0]      mst_r_id_i [NUM_PORTS],
  input  logic [demux_pkg::DATA_W-1:0]    mst_r_data_i [NUM_PORTS],
  input  demux_pkg::resp_e                mst_r_resp_i [NUM_PORTS],
  output logic [NUM_PORTS-1:0]            mst_r_ready_o
);

  txn_if wr_txn ();  // Write channel budget link
  txn_if rd_txn ();  // Read channel budget link

  // Payload fans out, the valids pick the port
  assign mst_aw_id_o   = aw_id_i;
  assign mst_aw_addr_o = aw_addr_i;
  assign mst_w_data_o  = w_data_i;
  assign mst_w_strb_o  = w_strb_i;
  assign mst_ar_id_o   = ar_id_i;
  assign mst_ar_addr_o = ar_addr_i;

  // Only the locked port has responses owed, so ready can fan out
  assign mst_b_ready_o = {NUM_PORTS{b_ready_i}};
  assign mst_r_ready_o = {NUM_PORTS{r_ready_i}};

  write_route #(
    .NUM_PORTS      ( NUM_PORTS      )
  ) i_write_route (
    .clk_i,
    .rst_n_i,
    .aw_valid_i,
    .aw_ready_o,
    .aw_select_i,
    .w_valid_i,
    .w_ready_o,
    .mst_aw_valid_o,
    .mst_aw_ready_i,
    .mst_w_valid_o,
    .mst_w_ready_i,
    .mst_b_valid_i,
    .mst_b_id_i,
    .mst_b_resp_i,
    .b_valid_o,
    .b_ready_i,
    .b_id_o,
    .b_resp_o,
    .txn            ( wr_txn.route   )
  );

  read_route #(
    .NUM_PORTS      ( NUM_PORTS      )
  ) i_read_route (
    .clk_i,
    .rst_n_i,
    .ar_valid_i,
    .ar_ready_o,
    .ar_select_i,
    .mst_ar_valid_o,
    .mst_ar_ready_i,
    .mst_r_valid_i,
    .mst_r_id_i,
    .mst_r_data_i,
    .mst_r_resp_i,
    .r_valid_o,
    .r_ready_i,
    .r_id_o,
    .r_data_o,
    .r_resp_o,
    .txn            ( rd_txn.route   )
  );

  txn_budget #(
    .MAX_TRANS      ( MAX_TRANS      )
  ) i_txn_budget (
    .clk_i,
    .rst_n_i,
    .wr             ( wr_txn.budget  ),
    .rd             ( rd_txn.budget  )
  );

endmodule

// ==== logic/demux_pkg.sv ====
/*
 * Shared definitions for the single-beat AXI demux
 * Payload widths, response codes and write path states
 */
package demux_pkg;

  // Payload widths
  localparam int unsigned ID_W   = 4;   // Transaction ID
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;  // Strobe is DATA_W/8 bits

  // AXI response codes, as on the wire
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,  // Exclusive access done
    SLVERR = 2'b10,  // Slave saw an error
    DECERR = 2'b11   // Nothing at this address
  } resp_e;

  // W tracking on the write path
  typedef enum logic {
    W_IDLE = 1'b0,  // No W owed
    W_DATA = 1'b1   // AW taken, its W not through yet
  } wr_state_e;

endpackage

// ==== logic/read_route.sv ====
/*
 * Read path of the AXI demux
 * AR goes to the selected port, R comes back from the locked port
 */
`timescale 1ns/1ps

module read_route #(
  parameter  int unsigned NUM_PORTS = 3,
  localparam int unsigned SEL_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Slave side request
  input  logic                          ar_valid_i,
  output logic                          ar_ready_o,
  input  logic [SEL_W-1:0]              ar_select_i,  // Stable while ar_valid_i
  // Master side request
  output logic [NUM_PORTS-1:0]          mst_ar_valid_o,
  input  logic [NUM_PORTS-1:0]          mst_ar_ready_i,
  // Master side responses
  input  logic [NUM_PORTS-1:0]          mst_r_valid_i,
  input  logic [demux_pkg::ID_W-1:0]    mst_r_id_i [NUM_PORTS],
  input  logic [demux_pkg::DATA_W-1:0]  mst_r_data_i [NUM_PORTS],
  input  demux_pkg::resp_e              mst_r_resp_i [NUM_PORTS],
  // Slave side response
  output logic                          r_valid_o,
  input  logic                          r_ready_i,
  output logic [demux_pkg::ID_W-1:0]    r_id_o,
  output logic [demux_pkg::DATA_W-1:0]  r_data_o,
  output demux_pkg::resp_e              r_resp_o,
  // Budget link
  txn_if.route                          txn
);

  logic [SEL_W-1:0] lock_q;  // Port that owns outstanding reads
  logic             ar_allow;
  logic             ar_sel_ready;
  logic             ar_xfer;

  // Budget room, and stay on the locked port until drained
  assign ar_allow = !txn.full && (txn.idle || (ar_select_i == lock_q));

  always_comb begin
    ar_sel_ready = 1'b0;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      mst_ar_valid_o[p] = ar_valid_i && ar_allow && (ar_select_i == SEL_W'(p));
      if (ar_select_i == SEL_W'(p)) begin
        ar_sel_ready = mst_ar_ready_i[p];
      end
    end
  end

  assign ar_ready_o = ar_allow && ar_sel_ready;
  assign ar_xfer    = ar_valid_i && ar_ready_o;

  // R mux from the locked port, in issue order there
  assign r_valid_o = mst_r_valid_i[lock_q];
  assign r_id_o    = mst_r_id_i[lock_q];
  assign r_data_o  = mst_r_data_i[lock_q];
  assign r_resp_o  = mst_r_resp_i[lock_q];

  assign txn.issue  = ar_xfer;
  assign txn.retire = r_valid_o && r_ready_i;  // Every R is last

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= '0;
    end else if (ar_xfer) begin
      lock_q <= ar_select_i;
    end
  end

endmodule

// ==== logic/txn_budget.sv ====
/*
 * Outstanding transaction budget
 * Per-channel counts, idle flags and the shared MAX_TRANS limit
 */
`timescale 1ns/1ps

module txn_budget #(
  parameter  int unsigned MAX_TRANS = 4,
  localparam int unsigned CNT_W     = $clog2(MAX_TRANS + 1)
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  txn_if.budget wr,  // Write channel
  txn_if.budget rd   // Read channel
);

  localparam int unsigned SUM_W = CNT_W + 1;  // Room for both counts

  logic [CNT_W-1:0] wr_cnt_q;
  logic [CNT_W-1:0] rd_cnt_q;
  logic [SUM_W-1:0] sum;
  logic             at_limit;
  logic             one_left;

  assign sum      = {1'b0, wr_cnt_q} + {1'b0, rd_cnt_q};
  assign at_limit = (sum == SUM_W'(MAX_TRANS));
  assign one_left = (sum == SUM_W'(MAX_TRANS - 1));

  assign wr.idle = (wr_cnt_q == '0);
  assign rd.idle = (rd_cnt_q == '0);

  // Both channels could take the last slot in one cycle
  // so the write wins it and the read waits
  assign wr.full = at_limit;
  assign rd.full = at_limit || (one_left && wr.issue);

  // Issue and retire together leave a count unchanged
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_cnt_q <= '0;
      rd_cnt_q <= '0;
    end else begin
      wr_cnt_q <= wr_cnt_q + CNT_W'(wr.issue) - CNT_W'(wr.retire);
      rd_cnt_q <= rd_cnt_q + CNT_W'(rd.issue) - CNT_W'(rd.retire);
    end
  end

endmodule

// ==== logic/txn_if.sv ====
/*
 * Budget link for one channel
 * Route side reports issue and retire, budget answers idle and full
 */
`timescale 1ns/1ps

interface txn_if;

  logic issue;   // Request handed to a master, one cycle
  logic retire;  // Response taken by the slave, one cycle
  logic idle;    // Nothing outstanding on this channel
  logic full;    // Reads plus writes at the limit

  // Route block side
  modport route (
    output issue,
    output retire,
    input  idle,
    input  full
  );

  // Counter side
  modport budget (
    input  issue,
    input  retire,
    output idle,
    output full
  );

endinterface

// ==== logic/write_route.sv ====
/*
 * Write path of the AXI demux
 * AW goes to the selected port, W and B follow the locked port
 */
`timescale 1ns/1ps

module write_route #(
  parameter  int unsigned NUM_PORTS = 3,
  localparam int unsigned SEL_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Slave side requests
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  logic [SEL_W-1:0]            aw_select_i,  // Stable while aw_valid_i
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  // Master side requests
  output logic [NUM_PORTS-1:0]        mst_aw_valid_o,
  input  logic [NUM_PORTS-1:0]        mst_aw_ready_i,
  output logic [NUM_PORTS-1:0]        mst_w_valid_o,
  input  logic [NUM_PORTS-1:0]        mst_w_ready_i,
  // Master side responses
  input  logic [NUM_PORTS-1:0]        mst_b_valid_i,
  input  logic [demux_pkg::ID_W-1:0]  mst_b_id_i [NUM_PORTS],
  input  demux_pkg::resp_e            mst_b_resp_i [NUM_PORTS],
  // Slave side response
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output logic [demux_pkg::ID_W-1:0]  b_id_o,
  output demux_pkg::resp_e            b_resp_o,
  // Budget link
  txn_if.route                        txn
);

  demux_pkg::wr_state_e state_q;
  demux_pkg::wr_state_e state_d;
  logic [SEL_W-1:0]     lock_q;       // Port that owns outstanding writes
  logic                 aw_allow;
  logic                 aw_sel_ready;
  logic                 w_owed;
  logic                 aw_xfer;
  logic                 w_xfer;
  logic                 b_xfer;

  assign w_owed = (state_q == demux_pkg::W_DATA);

  // No W owed, room in budget, and no port change while busy
  assign aw_allow = !w_owed && !txn.full &&
                    (txn.idle || (aw_select_i == lock_q));

  // AW valid only on the selected port
  always_comb begin
    aw_sel_ready = 1'b0;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      mst_aw_valid_o[p] = aw_valid_i && aw_allow && (aw_select_i == SEL_W'(p));
      if (aw_select_i == SEL_W'(p)) begin
        aw_sel_ready = mst_aw_ready_i[p];  // Out of range select never gets ready
      end
    end
  end

  assign aw_ready_o = aw_allow && aw_sel_ready;
  assign aw_xfer    = aw_valid_i && aw_ready_o;

  // The single W beat follows its AW to the locked port
  always_comb begin
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      mst_w_valid_o[p] = w_owed && w_valid_i && (lock_q == SEL_W'(p));
    end
  end

  assign w_ready_o = w_owed && mst_w_ready_i[lock_q];
  assign w_xfer    = w_valid_i && w_ready_o;

  // Only the locked port can hold a B
  assign b_valid_o = mst_b_valid_i[lock_q];
  assign b_id_o    = mst_b_id_i[lock_q];
  assign b_resp_o  = mst_b_resp_i[lock_q];
  assign b_xfer    = b_valid_o && b_ready_i;

  assign txn.issue  = aw_xfer;
  assign txn.retire = b_xfer;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      demux_pkg::W_IDLE: if (aw_xfer) state_d = demux_pkg::W_DATA;
      demux_pkg::W_DATA: if (w_xfer)  state_d = demux_pkg::W_IDLE;  // Beat is always last
      default:                        state_d = demux_pkg::W_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= demux_pkg::W_IDLE;
      lock_q  <= '0;
    end else begin
      state_q <= state_d;
      if (aw_xfer) begin
        lock_q <= aw_select_i;  // Same value when already locked
      end
    end
  end

endmodule
